// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = priv_tb
FILELIST  = verilog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: csr_regfile.sv
`timescale 1ns/100ps

module csr_regfile (
    input  logic                  clk,
    input  logic                  rstn,
    input  priv_pkg::csr_req_t    csr_req,
    input  logic                  restore,
    input  priv_pkg::tlb_cmd_t    tlb_cmd,
    input  priv_pkg::tlb_result_t tlb_res,
    output priv_pkg::word_t       rdata,
    output priv_pkg::word_t       era,
    output priv_pkg::tlb_entry_t  wr_entry,
    output priv_pkg::vppn_t       srch_vppn,
    output priv_pkg::asid_t       cur_asid,
    output priv_pkg::tlb_index_t  rd_index
);
    import priv_pkg::*;

    word_t crmd;
    word_t prmd;
    word_t tlbidx;   // ne at bit 31
    word_t tlbehi;
    word_t tlbelo0;
    word_t tlbelo1;
    word_t asid;

    function automatic word_t merge(word_t old, csr_req_t req);
        return (old & ~req.wmask) | (req.wdata & req.wmask);
    endfunction

    always_comb begin
        case (csr_req.addr)
            CSR_CRMD:    rdata = crmd;
            CSR_PRMD:    rdata = prmd;
            CSR_ERA:     rdata = era;
            CSR_TLBIDX:  rdata = tlbidx;
            CSR_TLBEHI:  rdata = tlbehi;
            CSR_TLBELO0: rdata = tlbelo0;
            CSR_TLBELO1: rdata = tlbelo1;
            CSR_ASID:    rdata = asid;
            default:     rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd    <= 32'h8;   // da=1
            prmd    <= '0;
            era     <= '0;
            tlbidx  <= '0;
            tlbehi  <= '0;
            tlbelo0 <= '0;
            tlbelo1 <= '0;
            asid    <= '0;
        end else if (csr_req.query_en) begin
            case (csr_req.addr)
                CSR_CRMD:    crmd    <= merge(crmd, csr_req);
                CSR_PRMD:    prmd    <= merge(prmd, csr_req);
                CSR_ERA:     era     <= merge(era, csr_req);
                CSR_TLBIDX:  tlbidx  <= merge(tlbidx, csr_req);
                CSR_TLBEHI:  tlbehi  <= merge(tlbehi, csr_req);
                CSR_TLBELO0: tlbelo0 <= merge(tlbelo0, csr_req);
                CSR_TLBELO1: tlbelo1 <= merge(tlbelo1, csr_req);
                CSR_ASID:    asid    <= merge(asid, csr_req);
                default: ;
            endcase
        end else if (restore) begin
            crmd[2:0] <= prmd[2:0];   // pplv, pie
        end else if (tlb_cmd.srch) begin
            tlbidx[31] <= ~tlb_res.hit;
            if (tlb_res.hit)
                tlbidx[2:0] <= tlb_res.hit_index;   // index kept on a miss
        end else if (tlb_cmd.rd) begin
            tlbehi     <= {tlb_res.entry.vppn, 13'd0};
            tlbelo0    <= tlb_res.entry.lo0;
            tlbelo1    <= tlb_res.entry.lo1;
            asid[9:0]  <= tlb_res.entry.asid;
            tlbidx[31] <= ~tlb_res.entry.e;
        end
    end

    always_comb begin
        wr_entry.e    = ~tlbidx[31];
        wr_entry.g    = tlbelo0[6] & tlbelo1[6];
        wr_entry.asid = asid[9:0];
        wr_entry.vppn = tlbehi[31:13];
        wr_entry.lo0  = tlbelo0;
        wr_entry.lo1  = tlbelo1;
    end

    assign srch_vppn = tlbehi[31:13];
    assign cur_asid  = asid[9:0];
    assign rd_index  = tlbidx[2:0];

endmodule

// File: priv_clock_gen.sv
`timescale 1ns/100ps

module priv_clock_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
    end

endmodule

// File: priv_exec.sv
`timescale 1ns/100ps

module priv_exec (
    input  logic                clk,
    input  logic                rstn,
    input  logic                en_in,
    input  priv_pkg::priv_op_t  op,
    input  priv_pkg::word_t     csr_rdata,
    input  priv_pkg::word_t     era,
    output logic                en_out,
    output logic                flush,
    output logic                stall,
    output logic                restore,
    output priv_pkg::word_t     pc_target,
    output priv_pkg::word_t     result,
    output logic [4:0]          addr_out,
    output priv_pkg::csr_req_t  csr_req,
    output priv_pkg::tlb_cmd_t  tlb_cmd
);
    import priv_pkg::*;

    priv_state_t state;
    priv_state_t next_state;
    tlb_cmd_t    cmd_q;
    logic        fill_mode;
    tlb_index_t  fill_cnt;
    logic        accept;
    logic        is_inv;
    logic [2:0]  tlb_sub;
    logic [2:0]  inv_op;
    word_t       wmask;

    // only one class flag may be set
    assign accept = en_in && ({op.is_csr, op.is_tlb, op.is_ertn} inside {3'b100, 3'b010, 3'b001});

    assign is_inv  = op.inst[16:15] == 2'b11;
    assign tlb_sub = op.inst[12:10];

    always_comb begin
        if (op.inst[4:0] == 5'd0)
            inv_op = 3'd1;          // op 0 behaves as op 1
        else if (op.inst[4:0] >= 5'd7)
            inv_op = 3'd7;          // no-op
        else
            inv_op = op.inst[2:0];
    end

    // csrwr full, csrrd none, csrxchg rj
    assign wmask = (op.inst[9:5] == 5'd1) ? '1 : (op.inst[9:5] == 5'd0) ? '0 : op.sr0;

    // tlbwr takes TLBIDX, read through the csr port while in TLB
    always_comb begin
        tlb_cmd = cmd_q;
        tlb_cmd.index = fill_mode ? fill_cnt : csr_rdata[2:0];
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            state <= INIT;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            INIT: begin
                if (accept && op.is_csr)
                    next_state = CSR;
                else if (accept && op.is_tlb)
                    next_state = TLB;
                else if (accept && op.is_ertn)
                    next_state = ERTN;
            end
            CSR:  next_state = DONE_CSR;
            TLB:  next_state = DONE_TLB;
            ERTN: next_state = DONE_ERTN;
            default: next_state = INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            en_out    <= 1'b0;
            flush     <= 1'b0;
            stall     <= 1'b0;
            restore   <= 1'b0;
            pc_target <= '0;
            result    <= '0;
            addr_out  <= '0;
            csr_req   <= '0;
            cmd_q     <= '0;
            fill_mode <= 1'b0;
            fill_cnt  <= '0;
        end else begin
            case (next_state)
                INIT: begin
                    en_out   <= 1'b0;
                    flush    <= 1'b0;
                    result   <= '0;
                    addr_out <= '0;
                end
                CSR: begin
                    pc_target        <= op.pc_next;
                    stall            <= 1'b1;
                    addr_out         <= op.addr;
                    csr_req.query_en <= 1'b1;
                    csr_req.addr     <= op.imm[13:0];
                    csr_req.wmask    <= wmask;
                    csr_req.wdata    <= op.sr1;
                end
                TLB: begin
                    pc_target        <= op.pc_next;
                    stall            <= 1'b1;
                    csr_req.addr     <= CSR_TLBIDX;
                    fill_mode        <= !is_inv && tlb_sub == 3'd5;
                    cmd_q.srch       <= !is_inv && tlb_sub == 3'd2;
                    cmd_q.rd         <= !is_inv && tlb_sub == 3'd3;
                    cmd_q.we         <= !is_inv && (tlb_sub == 3'd4 || tlb_sub == 3'd5);
                    cmd_q.inv        <= is_inv;
                    cmd_q.inv_op     <= inv_op;
                    cmd_q.clear_asid <= op.sr0[9:0];
                    cmd_q.clear_vppn <= op.sr1[31:13];
                end
                ERTN: begin
                    pc_target <= era;
                    restore   <= 1'b1;
                    stall     <= 1'b1;
                end
                DONE_CSR: begin
                    en_out           <= 1'b1;
                    flush            <= 1'b1;
                    stall            <= 1'b0;
                    result           <= csr_rdata;   // old value
                    csr_req.query_en <= 1'b0;
                end
                DONE_TLB: begin
                    en_out     <= 1'b1;
                    flush      <= 1'b1;
                    stall      <= 1'b0;
                    cmd_q.srch <= 1'b0;
                    cmd_q.rd   <= 1'b0;
                    cmd_q.we   <= 1'b0;
                    cmd_q.inv  <= 1'b0;
                    if (fill_mode)
                        fill_cnt <= fill_cnt + 1'b1;
                end
                DONE_ERTN: begin
                    en_out  <= 1'b1;
                    flush   <= 1'b1;
                    stall   <= 1'b0;
                    restore <= 1'b0;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: priv_pkg.sv
package priv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [9:0]  asid_t;
    typedef logic [18:0] vppn_t;
    typedef logic [2:0]  tlb_index_t;

    localparam int TLB_ENTRIES = 8;

    localparam csr_addr_t CSR_CRMD    = 14'h0;
    localparam csr_addr_t CSR_PRMD    = 14'h1;
    localparam csr_addr_t CSR_ERA     = 14'h6;
    localparam csr_addr_t CSR_TLBIDX  = 14'h10;
    localparam csr_addr_t CSR_TLBEHI  = 14'h11;
    localparam csr_addr_t CSR_TLBELO0 = 14'h12;
    localparam csr_addr_t CSR_TLBELO1 = 14'h13;
    localparam csr_addr_t CSR_ASID    = 14'h18;

    typedef enum logic [6:0] {
        INIT      = 7'b0000001,
        CSR       = 7'b0000010,
        TLB       = 7'b0000100,
        ERTN      = 7'b0001000,
        DONE_CSR  = 7'b0010000,
        DONE_TLB  = 7'b0100000,
        DONE_ERTN = 7'b1000000
    } priv_state_t;

    typedef struct packed {
        logic       is_csr;
        logic       is_tlb;
        logic       is_ertn;
        word_t      pc_next;
        word_t      inst;
        word_t      sr0;     // rj
        word_t      sr1;     // rk
        logic [4:0] addr;    // rd
        word_t      imm;
    } priv_op_t;

    typedef struct packed {
        logic      query_en;
        csr_addr_t addr;
        word_t     wmask;
        word_t     wdata;
    } csr_req_t;

    typedef struct packed {
        logic       srch;
        logic       rd;
        logic       we;
        logic       inv;
        tlb_index_t index;
        logic [2:0] inv_op;
        asid_t      clear_asid;
        vppn_t      clear_vppn;
    } tlb_cmd_t;

    typedef struct packed {
        logic  e;
        logic  g;
        asid_t asid;
        vppn_t vppn;
        word_t lo0;
        word_t lo1;
    } tlb_entry_t;

    typedef struct packed {
        logic       hit;
        tlb_index_t hit_index;
        tlb_entry_t entry;
    } tlb_result_t;

endpackage

// File: priv_properties.sv
`timescale 1ns/100ps

module priv_properties (
    input logic               clk,
    input logic               rstn,
    input logic               en_in,
    input priv_pkg::priv_op_t op,
    input logic               en_out,
    input logic               flush,
    input logic               stall
);

    int   fail_count = 0;
    logic accepted;

    // idle is the only state with stall and en_out both low
    assign accepted = en_in && !stall && !en_out && $onehot({op.is_csr, op.is_tlb, op.is_ertn});

    a_flush_with_en_out: assert property (@(posedge clk) disable iff (!rstn) flush == en_out)
        else begin
            fail_count++;
            $error("flush differs from en_out");
        end

    a_en_out_pulse: assert property (@(posedge clk) disable iff (!rstn) en_out |=> !en_out)
        else begin
            fail_count++;
            $error("en_out high for more than one cycle");
        end

    a_no_stall_at_done: assert property (@(posedge clk) disable iff (!rstn) !(stall && en_out))
        else begin
            fail_count++;
            $error("stall and en_out high together");
        end

    a_two_cycle_latency: assert property (@(posedge clk) disable iff (!rstn)
        accepted |=> !en_out ##1 en_out)
        else begin
            fail_count++;
            $error("en_out did not follow an accepted en_in after two cycles");
        end

endmodule

bind priv_top priv_properties i_priv_properties (
    .clk    (clk),
    .rstn   (rstn),
    .en_in  (en_in),
    .op     (op),
    .en_out (en_out),
    .flush  (flush),
    .stall  (stall)
);

// File: priv_stim.txt
# name flags(4=csr 2=tlb 1=ertn) pc_next inst sr0 sr1 addr imm exp_result exp_pc
# all values hex; exp_result is the old csr value for csr ops, 0 otherwise
wr_era           4 1c000000 04001824 00000000 1c0000a0 04 00000006 00000000 1c000000
wr_era_again     4 1c000004 04001824 00000000 1c000100 04 00000006 1c0000a0 1c000004
rd_era           4 1c000008 04001804 00000000 00000000 04 00000006 1c000100 1c000008
wr_asid          4 1c00000c 04006024 00000000 00000055 04 00000018 00000000 1c00000c
rd_asid          4 1c000010 04006004 00000000 00000000 04 00000018 00000055 1c000010
wr_prmd          4 1c000014 04000424 00000000 000000f0 04 00000001 00000000 1c000014
xchg_prmd        4 1c000018 040004a4 0000003c 000000a5 04 00000001 000000f0 1c000018
rd_prmd          4 1c00001c 04000404 00000000 00000000 04 00000001 000000e4 1c00001c
ertn             1 1c000020 06483800 00000000 00000000 00 00000000 00000000 1c000100
rd_crmd          4 1c000024 04000004 00000000 00000000 04 00000000 0000000c 1c000024
wr_tlbidx_3      4 1c000028 04004024 00000000 00000003 04 00000010 00000000 1c000028
wr_ehi_e3        4 1c00002c 04004424 00000000 12346000 04 00000011 00000000 1c00002c
wr_lo0_e3        4 1c000030 04004824 00000000 0abcd011 04 00000012 00000000 1c000030
wr_lo1_e3        4 1c000034 04004c24 00000000 0abce011 04 00000013 00000000 1c000034
tlbwr_e3         2 1c000038 06483000 00000000 00000000 00 00000000 00000000 1c000038
wr_tlbidx_2      4 1c00003c 04004024 00000000 00000002 04 00000010 00000003 1c00003c
wr_ehi_e2        4 1c000040 04004424 00000000 00c00000 04 00000011 12346000 1c000040
tlbwr_e2         2 1c000044 06483000 00000000 00000000 00 00000000 00000000 1c000044
wr_ehi_e0        4 1c000048 04004424 00000000 00400000 04 00000011 00c00000 1c000048
wr_lo0_e0        4 1c00004c 04004824 00000000 00100051 04 00000012 0abcd011 1c00004c
wr_lo1_e0        4 1c000050 04004c24 00000000 00101051 04 00000013 0abce011 1c000050
tlbfill_e0       2 1c000054 06483400 00000000 00000000 00 00000000 00000000 1c000054
wr_ehi_e1        4 1c000058 04004424 00000000 00800000 04 00000011 00400000 1c000058
wr_lo0_e1        4 1c00005c 04004824 00000000 00200011 04 00000012 00100051 1c00005c
wr_asid_e1       4 1c000060 04006024 00000000 00000066 04 00000018 00000055 1c000060
tlbfill_e1       2 1c000064 06483400 00000000 00000000 00 00000000 00000000 1c000064
wr_tlbidx_0      4 1c000068 04004024 00000000 00000000 04 00000010 00000002 1c000068
tlbrd_e0         2 1c00006c 06482c00 00000000 00000000 00 00000000 00000000 1c00006c
rd_ehi_e0        4 1c000070 04004404 00000000 00000000 04 00000011 00400000 1c000070
rd_lo0_e0        4 1c000074 04004804 00000000 00000000 04 00000012 00100051 1c000074
wr_tlbidx_1      4 1c000078 04004024 00000000 00000001 04 00000010 00000000 1c000078
tlbrd_e1         2 1c00007c 06482c00 00000000 00000000 00 00000000 00000000 1c00007c
rd_ehi_e1        4 1c000080 04004404 00000000 00000000 04 00000011 00800000 1c000080
rd_lo0_e1        4 1c000084 04004804 00000000 00000000 04 00000012 00200011 1c000084
wr_ehi_s3        4 1c000088 04004424 00000000 12346000 04 00000011 00800000 1c000088
wr_asid_55       4 1c00008c 04006024 00000000 00000055 04 00000018 00000066 1c00008c
tlbsrch_e3       2 1c000090 06482800 00000000 00000000 00 00000000 00000000 1c000090
rd_tlbidx_e3     4 1c000094 04004004 00000000 00000000 04 00000010 00000003 1c000094
invtlb_g1        2 1c000098 06498002 00000000 00000000 00 00000000 00000000 1c000098
wr_ehi_s0        4 1c00009c 04004424 00000000 00400000 04 00000011 12346000 1c00009c
tlbsrch_e0_gone  2 1c0000a0 06482800 00000000 00000000 00 00000000 00000000 1c0000a0
rd_tlbidx_e0     4 1c0000a4 04004004 00000000 00000000 04 00000010 80000003 1c0000a4
wr_ehi_s1        4 1c0000a8 04004424 00000000 00800000 04 00000011 00400000 1c0000a8
wr_asid_66       4 1c0000ac 04006024 00000000 00000066 04 00000018 00000055 1c0000ac
tlbsrch_e1_kept  2 1c0000b0 06482800 00000000 00000000 00 00000000 00000000 1c0000b0
rd_tlbidx_e1     4 1c0000b4 04004004 00000000 00000000 04 00000010 00000001 1c0000b4
invtlb_asid      2 1c0000b8 06498004 00000066 00000000 00 00000000 00000000 1c0000b8
tlbsrch_e1_gone  2 1c0000bc 06482800 00000000 00000000 00 00000000 00000000 1c0000bc
rd_tlbidx_e1_gone 4 1c0000c0 04004004 00000000 00000000 04 00000010 80000001 1c0000c0
wr_ehi_s3b       4 1c0000c4 04004424 00000000 12346000 04 00000011 00800000 1c0000c4
wr_asid_55b      4 1c0000c8 04006024 00000000 00000055 04 00000018 00000066 1c0000c8
tlbsrch_e3_kept  2 1c0000cc 06482800 00000000 00000000 00 00000000 00000000 1c0000cc
rd_tlbidx_e3_kept 4 1c0000d0 04004004 00000000 00000000 04 00000010 00000003 1c0000d0
invtlb_asid_va   2 1c0000d4 06498005 00000055 12346000 00 00000000 00000000 1c0000d4
tlbsrch_e3_gone  2 1c0000d8 06482800 00000000 00000000 00 00000000 00000000 1c0000d8
rd_tlbidx_e3_gone 4 1c0000dc 04004004 00000000 00000000 04 00000010 80000003 1c0000dc
wr_ehi_s2        4 1c0000e0 04004424 00000000 00c00000 04 00000011 12346000 1c0000e0
tlbsrch_e2_kept  2 1c0000e4 06482800 00000000 00000000 00 00000000 00000000 1c0000e4
rd_tlbidx_e2     4 1c0000e8 04004004 00000000 00000000 04 00000010 00000002 1c0000e8
wr_tlbidx_5      4 1c0000ec 04004024 00000000 00000005 04 00000010 00000002 1c0000ec
tlbrd_empty      2 1c0000f0 06482c00 00000000 00000000 00 00000000 00000000 1c0000f0
rd_tlbidx_empty  4 1c0000f4 04004004 00000000 00000000 04 00000010 80000005 1c0000f4

// File: priv_tb.sv
`timescale 1ns/100ps

module priv_tb;
    import priv_pkg::*;

    logic       clk;
    logic       rstn;
    logic       en_in;
    priv_op_t   op;
    logic       en_out;
    logic       flush;
    logic       stall;
    word_t      pc_target;
    word_t      result;
    logic [4:0] addr_out;

    int tests;
    int errors;
    int test_errors;
    bit timed_out;

    priv_clock_gen i_priv_clock_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    priv_top i_priv_top (
        .clk       (clk),
        .rstn      (rstn),
        .en_in     (en_in),
        .op        (op),
        .en_out    (en_out),
        .flush     (flush),
        .stall     (stall),
        .pc_target (pc_target),
        .result    (result),
        .addr_out  (addr_out)
    );

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("mismatch %0s result expected %08h actual %08h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_pc(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("mismatch %0s pc_target expected %08h actual %08h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (exp !== act) begin
            $display("mismatch %0s addr_out expected %02h actual %02h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_level(input string name, input string sig, input logic exp,
                               input logic act);
        if (exp !== act) begin
            $display("mismatch %0s %0s expected %0b actual %0b", name, sig, exp, act);
            test_errors++;
        end
    endtask

    // one instruction, then wait for its en_out pulse
    task automatic run_instr(input string name, input priv_op_t next_op,
                             input word_t exp_result, input word_t exp_pc,
                             input logic [4:0] exp_addr);
        int cycles;
        test_errors = 0;
        @(posedge clk);
        #2;
        en_in = 1'b1;
        op    = next_op;
        @(posedge clk);
        #2;
        en_in = 1'b0;
        check_level(name, "stall", 1'b1, stall);   // busy right after accept
        cycles = 0;
        while (!en_out && cycles < 20) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        tests++;
        if (!en_out) begin
            $display("%0s: en_out never came within 20 cycles", name);
            timed_out = 1'b1;
            errors++;
        end else begin
            check_word(name, exp_result, result);
            check_pc(name, exp_pc, pc_target);
            check_addr(name, exp_addr, addr_out);
            check_level(name, "flush", 1'b1, flush);
            check_level(name, "stall", 1'b0, stall);
            errors += test_errors;
            if (test_errors == 0)
                $display("%0s: ok", name);
            else
                $display("%0s: %0d errors", name, test_errors);
        end
    endtask

    initial begin
        int              fd;
        int              n;
        int              cycles;
        string           line;
        logic [8*32-1:0] tname;
        logic [2:0]      flags;
        word_t           pc_next;
        word_t           inst;
        word_t           sr0;
        word_t           sr1;
        logic [4:0]      addr;
        word_t           imm;
        word_t           exp_result;
        word_t           exp_pc;
        logic [4:0]      exp_addr;
        priv_op_t        next_op;

        en_in     = 1'b0;
        op        = '0;
        tests     = 0;
        errors    = 0;
        timed_out = 1'b0;

        cycles = 0;
        while (!rstn && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end

        fd = $fopen("priv_stim.txt", "r");
        if (rstn == 1'b0) begin
            $display("reset was never released");
            errors++;
        end else if (fd == 0) begin
            $display("could not open priv_stim.txt");
            errors++;
        end else begin
            while (!timed_out && !$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", tname, flags, pc_next,
                                inst, sr0, sr1, addr, imm, exp_result, exp_pc);
                    if (n == 10) begin
                        next_op         = '0;
                        next_op.is_csr  = flags[2];
                        next_op.is_tlb  = flags[1];
                        next_op.is_ertn = flags[0];
                        next_op.pc_next = pc_next;
                        next_op.inst    = inst;
                        next_op.sr0     = sr0;
                        next_op.sr1     = sr1;
                        next_op.addr    = addr;
                        next_op.imm     = imm;
                        exp_addr        = flags[2] ? addr : 5'd0;   // only csr ops write rd
                        run_instr($sformatf("%0s", tname), next_op, exp_result, exp_pc,
                                  exp_addr);
                    end
                end
            end
            $fclose(fd);
        end

        if (i_priv_top.i_priv_properties.fail_count != 0) begin
            $display("%0d assertion failures", i_priv_top.i_priv_properties.fail_count);
            errors += i_priv_top.i_priv_properties.fail_count;
        end
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0 && tests > 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: priv_top.sv
`timescale 1ns/100ps

module priv_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               en_in,
    input  priv_pkg::priv_op_t op,
    output logic               en_out,
    output logic               flush,
    output logic               stall,
    output priv_pkg::word_t    pc_target,
    output priv_pkg::word_t    result,
    output logic [4:0]         addr_out
);
    import priv_pkg::*;

    word_t                  csr_rdata;
    word_t                  era;
    logic                   restore;
    csr_req_t               csr_req;
    tlb_cmd_t               tlb_cmd;
    tlb_entry_t             wr_entry;
    vppn_t                  srch_vppn;
    asid_t                  cur_asid;
    tlb_index_t             rd_index;
    tlb_result_t            tlb_res;
    logic [TLB_ENTRIES-1:0] match;
    tlb_entry_t             entries [TLB_ENTRIES];

    priv_exec i_priv_exec (
        .clk       (clk),
        .rstn      (rstn),
        .en_in     (en_in),
        .op        (op),
        .csr_rdata (csr_rdata),
        .era       (era),
        .en_out    (en_out),
        .flush     (flush),
        .stall     (stall),
        .restore   (restore),
        .pc_target (pc_target),
        .result    (result),
        .addr_out  (addr_out),
        .csr_req   (csr_req),
        .tlb_cmd   (tlb_cmd)
    );

    csr_regfile i_csr_regfile (
        .clk       (clk),
        .rstn      (rstn),
        .csr_req   (csr_req),
        .restore   (restore),
        .tlb_cmd   (tlb_cmd),
        .tlb_res   (tlb_res),
        .rdata     (csr_rdata),
        .era       (era),
        .wr_entry  (wr_entry),
        .srch_vppn (srch_vppn),
        .cur_asid  (cur_asid),
        .rd_index  (rd_index)
    );

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        tlb_entry i_tlb_entry (
            .clk       (clk),
            .rstn      (rstn),
            .we        (tlb_cmd.we && tlb_cmd.index == tlb_index_t'(i)),
            .wr_entry  (wr_entry),
            .tlb_cmd   (tlb_cmd),
            .srch_vppn (srch_vppn),
            .cur_asid  (cur_asid),
            .entry     (entries[i]),
            .match     (match[i])
        );
    end

    tlb_lookup i_tlb_lookup (
        .match    (match),
        .entries  (entries),
        .rd_index (rd_index),
        .res      (tlb_res)
    );

endmodule

// File: tlb_entry.sv
`timescale 1ns/100ps

module tlb_entry (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 we,
    input  priv_pkg::tlb_entry_t wr_entry,
    input  priv_pkg::tlb_cmd_t   tlb_cmd,
    input  priv_pkg::vppn_t      srch_vppn,
    input  priv_pkg::asid_t      cur_asid,
    output priv_pkg::tlb_entry_t entry,
    output logic                 match
);
    import priv_pkg::*;

    tlb_entry_t data;
    logic       valid;
    logic       asid_eq;
    logic       vppn_eq;
    logic       inv_hit;

    assign asid_eq = data.asid == tlb_cmd.clear_asid;
    assign vppn_eq = data.vppn == tlb_cmd.clear_vppn;

    always_comb begin
        case (tlb_cmd.inv_op)
            3'd1:    inv_hit = 1'b1;
            3'd2:    inv_hit = data.g;
            3'd3:    inv_hit = !data.g;
            3'd4:    inv_hit = !data.g && asid_eq;
            3'd5:    inv_hit = !data.g && asid_eq && vppn_eq;
            3'd6:    inv_hit = (data.g || asid_eq) && vppn_eq;
            default: inv_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            valid <= 1'b0;
        else if (we)
            valid <= wr_entry.e;
        else if (tlb_cmd.inv && inv_hit)
            valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (we)
            data <= wr_entry;
    end

    always_comb begin
        entry   = data;
        entry.e = valid;
    end

    assign match = valid && data.vppn == srch_vppn && (data.g || data.asid == cur_asid);

endmodule

// File: tlb_lookup.sv
`timescale 1ns/100ps

module tlb_lookup (
    input  logic [priv_pkg::TLB_ENTRIES-1:0] match,
    input  priv_pkg::tlb_entry_t             entries [priv_pkg::TLB_ENTRIES],
    input  priv_pkg::tlb_index_t             rd_index,
    output priv_pkg::tlb_result_t            res
);
    import priv_pkg::*;

    always_comb begin
        res = '0;
        res.hit = |match;
        // walk down so the lowest match wins
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i])
                res.hit_index = tlb_index_t'(i);
        end
        res.entry = entries[rd_index];   // for tlbrd
    end

endmodule

// File: verilog.f
priv_pkg.sv
priv_exec.sv
csr_regfile.sv
tlb_entry.sv
tlb_lookup.sv
priv_top.sv
priv_clock_gen.sv
priv_properties.sv
priv_tb.sv
